// File: all.f
+incdir+include
source/bus_pkg.sv
source/map_pkg.sv
source/io_decoder.sv
source/mem_decoder.sv
source/dma_arbiter.sv
source/nmi_control.sv
source/board_glue.sv
tests/board_glue_tb.sv

// File: include/board_glue_vectors.svh
////////////////////////////////////////////////////////////////////////////
// Decode vectors for the board glue testbench
// row type, row count and the table loader
////////////////////////////////////////////////////////////////////////////

`ifndef board_glue_vectors_svh
`define board_glue_vectors_svh

// columns: addr, cmd, data, parity, board_ctrl, dma_chan, then expected
// io_sel, mem_sel, dma_page and nmi in the cycle after acceptance
typedef struct packed {
   bus_cycle_t            cyc;
   board_ctrl_t           ctrl;
   logic [1:0]            chan;
   io_select_t            io;
   mem_select_t           mem;
   logic [page_width-1:0] page;
   logic                  nmi;
} vector_t;

localparam int num_vectors = 32;

task automatic load_vectors;
   // peripheral groups, then ports that select nothing
   vectors[0]  = make_row('h00000, io_read,   'h00, 0, 'b000, 0, 'b1000, 'h000, 'h0, 0);
   vectors[1]  = make_row('h00020, io_write,  'h00, 0, 'b000, 0, 'b0100, 'h000, 'h0, 0);
   vectors[2]  = make_row('h00043, io_read,   'h00, 0, 'b000, 0, 'b0010, 'h000, 'h0, 0);
   vectors[3]  = make_row('h00061, io_write,  'h00, 0, 'b000, 0, 'b0001, 'h000, 'h0, 0);
   vectors[4]  = make_row('h00100, io_read,   'h00, 0, 'b000, 0, 'b0000, 'h000, 'h0, 0);
   vectors[5]  = make_row('h00260, io_read,   'h00, 0, 'b000, 0, 'b0000, 'h000, 'h0, 0);
   vectors[6]  = make_row('h000c0, io_read,   'h00, 0, 'b000, 0, 'b0000, 'h000, 'h0, 0);
   vectors[7]  = make_row('h000e0, io_write,  'h00, 0, 'b000, 0, 'b0000, 'h000, 'h0, 0);
   vectors[8]  = make_row('h00040, mem_read,  'h00, 1, 'b000, 0, 'b0000, 'h001, 'h0, 0);
   // page registers read back per channel, then the NMI mask
   vectors[9]  = make_row('h00081, io_write,  'h0a, 0, 'b000, 1, 'b0000, 'h000, 'ha, 0);
   vectors[10] = make_row('h00082, io_write,  'h35, 0, 'b000, 2, 'b0000, 'h000, 'h5, 0);
   vectors[11] = make_row('h00083, io_write,  'hfc, 0, 'b000, 3, 'b0000, 'h000, 'hc, 0);
   vectors[12] = make_row('h00080, io_write,  'h07, 0, 'b000, 0, 'b0000, 'h000, 'h7, 0);
   vectors[13] = make_row('h00040, io_read,   'h00, 0, 'b000, 1, 'b0010, 'h000, 'ha, 0);
   vectors[14] = make_row('h00081, io_read,   'h00, 0, 'b000, 2, 'b0000, 'h000, 'h5, 0);
   vectors[15] = make_row('h000a0, io_write,  'h80, 0, 'b000, 3, 'b0000, 'h000, 'hc, 0);
   // ROM sockets and RAM banks
   vectors[16] = make_row('hf0000, mem_read,  'h00, 1, 'b000, 0, 'b0000, 'h010, 'h7, 0);
   vectors[17] = make_row('hfe000, mem_read,  'h00, 1, 'b000, 0, 'b0000, 'h800, 'h7, 0);
   vectors[18] = make_row('hf6000, mem_read,  'h00, 1, 'b000, 0, 'b0000, 'h080, 'h7, 0);
   vectors[19] = make_row('hf2000, mem_write, 'h00, 0, 'b000, 0, 'b0000, 'h000, 'h7, 0);
   vectors[20] = make_row('h10000, mem_write, 'h00, 0, 'b000, 0, 'b0000, 'h002, 'h7, 0);
   vectors[21] = make_row('h2abcd, mem_read,  'h01, 0, 'b000, 0, 'b0000, 'h004, 'h7, 0);
   vectors[22] = make_row('h3ffff, mem_write, 'h00, 0, 'b000, 0, 'b0000, 'h008, 'h7, 0);
   vectors[23] = make_row('h40000, mem_read,  'h00, 1, 'b000, 0, 'b0000, 'h000, 'h7, 0);
   // channel check, then a parity error seen through the mask
   vectors[24] = make_row('h00060, io_read,   'h00, 0, 'b011, 0, 'b0001, 'h000, 'h7, 1);
   vectors[25] = make_row('h00020, io_read,   'h00, 0, 'b010, 0, 'b0100, 'h000, 'h7, 1);
   vectors[26] = make_row('h00000, io_write,  'h00, 0, 'b000, 0, 'b1000, 'h000, 'h7, 0);
   vectors[27] = make_row('h00010, mem_read,  'h03, 0, 'b100, 0, 'b0000, 'h001, 'h7, 0);
   vectors[28] = make_row('h00040, io_read,   'h00, 0, 'b100, 0, 'b0010, 'h000, 'h7, 1);
   vectors[29] = make_row('h000a0, io_write,  'h00, 0, 'b100, 0, 'b0000, 'h000, 'h7, 0);
   vectors[30] = make_row('h000a0, io_write,  'h80, 0, 'b100, 0, 'b0000, 'h000, 'h7, 1);
   vectors[31] = make_row('h00000, io_read,   'h00, 0, 'b000, 0, 'b1000, 'h000, 'h7, 0);
endtask

`endif

// File: tests/board_glue_tb.sv
////////////////////////////////////////////////////////////////////////////
// Testbench for the board glue logic
// table driven decode checks, random RAM parity reads, DMA hold sequence
////////////////////////////////////////////////////////////////////////////

module board_glue_tb
   import bus_pkg::*;
   import map_pkg::*;
();

   localparam int clk_period   = 100;
   localparam int reset_cycles = 10;
   localparam int random_reads = 16;

   logic                  clk;
   logic                  reset_n;
   bus_cycle_t            cycle;
   logic                  cycle_valid;
   logic                  cycle_ready;
   logic                  bus_lock;
   logic                  hold_req;
   logic [1:0]            dma_chan;
   logic                  hold_ack;
   logic                  aen_brd;
   logic                  dma_aen;
   logic [page_width-1:0] dma_page;
   board_ctrl_t           board_ctrl;
   io_select_t            io_sel;
   mem_select_t           mem_sel;
   logic                  nmi;

   `include "board_glue_vectors.svh"

   localparam int cycle_limit = 4 * num_vectors + 200;

   vector_t     vectors [num_vectors];
   int          errors = 0;
   int          checks = 0;
   int          cycles = 0;
   logic [15:0] lfsr;

   board_glue DUT (
      .clk         (clk),
      .reset_n     (reset_n),
      .cycle       (cycle),
      .cycle_valid (cycle_valid),
      .cycle_ready (cycle_ready),
      .bus_lock    (bus_lock),
      .hold_req    (hold_req),
      .dma_chan    (dma_chan),
      .hold_ack    (hold_ack),
      .aen_brd     (aen_brd),
      .dma_aen     (dma_aen),
      .dma_page    (dma_page),
      .board_ctrl  (board_ctrl),
      .io_sel      (io_sel),
      .mem_sel     (mem_sel),
      .nmi         (nmi)
   );

   always #(clk_period / 2) clk = ~clk;

   // run limit from the table length
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= cycle_limit) begin
         $display("timeout after %0d cycles, the DUT never took a pending cycle", cycles);
         $display("Test failed");
         $finish;
      end
   end

   function automatic bus_cycle_t make_cycle(input logic [19:0] addr, input bus_cmd_t cmd,
                                             input logic [7:0] data, input logic parity);
      bus_cycle_t c;
      c.addr   = addr;
      c.cmd    = cmd;
      c.data   = data;
      c.parity = parity;
      return c;
   endfunction

   function automatic vector_t make_row(input logic [19:0] addr, input bus_cmd_t cmd,
                                        input logic [7:0] data, input logic parity,
                                        input logic [2:0] ctrl, input logic [1:0] chan,
                                        input logic [3:0] io_exp, input logic [11:0] mem_exp,
                                        input logic [3:0] page_exp, input logic nmi_exp);
      vector_t v;
      v.cyc  = make_cycle(addr, cmd, data, parity);
      v.ctrl = ctrl;
      v.chan = chan;
      v.io   = io_exp;
      v.mem  = mem_exp;
      v.page = page_exp;
      v.nmi  = nmi_exp;
      return v;
   endfunction

   // galois form with taps 16 14 13 11
   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      if (s[0]) begin
         return (s >> 1) ^ 16'hb400;
      end else begin
         return s >> 1;
      end
   endfunction

   function automatic int count_ones(input logic [8:0] v);
      int n;
      n = 0;
      for (int k = 0; k < 9; k++) begin
         n += v[k];
      end
      return n;
   endfunction

   task automatic take_bits(input int n, output logic [15:0] v);
      v = '0;
      for (int k = 0; k < n; k++) begin
         v    = {v[14:0], lfsr[0]};  // one step per bit
         lfsr = lfsr_step(lfsr);
      end
   endtask

   task automatic check_value(input string name, input logic [15:0] actual,
                              input logic [15:0] expected);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("FAILED %s: got %h, expected %h", name, actual, expected);
      end
   endtask

   task automatic check_hold(input logic ack, input logic aen, input logic daen,
                             input logic rdy);
      check_value("hold_ack", hold_ack, ack);
      check_value("aen_brd", aen_brd, aen);
      check_value("dma_aen", dma_aen, daen);
      check_value("cycle_ready", cycle_ready, rdy);
   endtask

   // called at a falling edge with a cycle presented
   task automatic wait_accept;
      while (!cycle_ready) begin
         @(negedge clk);
      end
      @(posedge clk);          // accepting edge
      cycle_valid <= 1'b0;
      @(negedge clk);          // decode outputs valid here
   endtask

   task automatic present_cycle(input bus_cycle_t c, input board_ctrl_t ctrl,
                                input logic [1:0] chan);
      @(posedge clk);
      cycle       <= c;
      board_ctrl  <= ctrl;
      dma_chan    <= chan;
      cycle_valid <= 1'b1;
      @(negedge clk);
      wait_accept();
   endtask

   task automatic run_table;
      vector_t v;
      for (int i = 0; i < num_vectors; i++) begin
         v = vectors[i];
         present_cycle(v.cyc, v.ctrl, v.chan);
         check_value("io_sel", io_sel, v.io);
         check_value("mem_sel", mem_sel, v.mem);
         check_value("dma_page", dma_page, v.page);
         check_value("nmi", nmi, v.nmi);
      end
   endtask

   task automatic run_parity_reads;
      logic [15:0] bits;
      logic [7:0]  data;
      logic        parity;
      logic [1:0]  bank;
      logic        bad;
      bus_cycle_t  c;
      mem_select_t e;
      for (int i = 0; i < random_reads; i++) begin
         take_bits(8, bits);
         data = bits[7:0];
         take_bits(1, bits);
         parity = bits[0];
         take_bits(2, bits);
         bank = bits[1:0];
         bad  = (count_ones({data, parity}) % 2) == 0;  // odd parity expected
         c = make_cycle({2'b00, bank, data, 8'h40}, mem_read, data, parity);
         e = '0;
         e.ram_bank[bank] = 1'b1;
         @(posedge clk);
         board_ctrl <= '0;  // clear the parity latch
         present_cycle(c, 3'b100, 2'd0);
         check_value("mem_sel", mem_sel, e);
         check_value("nmi", nmi, 1'b0);
         @(negedge clk);
         check_value("nmi", nmi, bad);
      end
   endtask

   task automatic run_dma_hold;
      bus_cycle_t c;
      io_select_t e;
      c       = make_cycle(20'h00040, io_read, 8'h00, 1'b0);
      e       = '0;
      e.timer = 1'b1;
      // a locked bus keeps the grant off
      @(posedge clk);
      bus_lock <= 1'b1;
      hold_req <= 1'b1;
      @(posedge clk);
      bus_lock <= 1'b0;
      @(negedge clk);
      check_hold(0, 0, 0, 1);
      // grant chain moves one stage per edge
      @(negedge clk);
      check_hold(1, 0, 0, 0);
      @(negedge clk);
      check_hold(1, 1, 0, 0);
      @(negedge clk);
      check_hold(1, 1, 1, 0);
      // CPU cycle waits while DMA owns the bus
      @(posedge clk);
      cycle       <= c;
      cycle_valid <= 1'b1;
      repeat (3) begin
         @(negedge clk);
         check_hold(1, 1, 1, 0);
         check_value("io_sel", io_sel, '0);
         check_value("mem_sel", mem_sel, '0);
      end
      @(posedge clk);
      hold_req <= 1'b0;
      @(negedge clk);
      @(negedge clk);
      check_hold(0, 1, 1, 0);  // hold_ack drops first
      @(negedge clk);
      check_hold(0, 0, 0, 1);
      check_value("io_sel", io_sel, '0);
      wait_accept();
      check_value("io_sel", io_sel, e);
      @(negedge clk);
      check_value("io_sel", io_sel, '0);  // one cycle only
   endtask

   initial begin
      clk         = 1'b0;
      reset_n     = 1'b0;
      cycle       = '0;
      cycle_valid = 1'b0;
      bus_lock    = 1'b0;
      hold_req    = 1'b0;
      dma_chan    = 2'd0;
      board_ctrl  = '0;
      lfsr        = 16'd97;
      load_vectors();
      repeat (reset_cycles) @(posedge clk);
      reset_n <= 1'b1;
      @(negedge clk);
      check_hold(0, 0, 0, 1);
      check_value("io_sel", io_sel, '0);
      check_value("mem_sel", mem_sel, '0);
      check_value("dma_page", dma_page, '0);
      check_value("nmi", nmi, 1'b0);
      run_table();
      run_parity_reads();
      run_dma_hold();
      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

// File: source/board_glue.sv
////////////////////////////////////////////////////////////////////////////
// System board glue logic, top level
// bus handshake, I/O and memory decode, DMA arbitration and NMI
////////////////////////////////////////////////////////////////////////////

module board_glue
   import bus_pkg::*;
   import map_pkg::*;
(
   input  logic                  clk,
   input  logic                  reset_n,
   // CPU side
   input  bus_cycle_t            cycle,
   input  logic                  cycle_valid,
   output logic                  cycle_ready,
   input  logic                  bus_lock,
   // DMA side
   input  logic                  hold_req,
   input  logic [1:0]            dma_chan,
   output logic                  hold_ack,
   output logic                  aen_brd,
   output logic                  dma_aen,
   output logic [page_width-1:0] dma_page,
   // board control and selects
   input  board_ctrl_t           board_ctrl,
   output io_select_t            io_sel,
   output mem_select_t           mem_sel,
   output logic                  nmi
);

   logic accept;       // cycle taken this clock
   logic parity_fail;
   logic nmi_enable;

   assign accept = cycle_valid && cycle_ready;

   io_decoder u_io_decoder (
      .clk        (clk),
      .reset_n    (reset_n),
      .cycle      (cycle),
      .accept     (accept),
      .dma_chan   (dma_chan),
      .io_sel     (io_sel),
      .dma_page   (dma_page),
      .nmi_enable (nmi_enable)
   );

   mem_decoder u_mem_decoder (
      .clk         (clk),
      .reset_n     (reset_n),
      .cycle       (cycle),
      .accept      (accept),
      .mem_sel     (mem_sel),
      .parity_fail (parity_fail)
   );

   dma_arbiter u_dma_arbiter (
      .clk         (clk),
      .reset_n     (reset_n),
      .hold_req    (hold_req),
      .cycle_valid (cycle_valid),
      .bus_lock    (bus_lock),
      .hold_ack    (hold_ack),
      .aen_brd     (aen_brd),
      .dma_aen     (dma_aen),
      .cycle_ready (cycle_ready)
   );

   nmi_control u_nmi_control (
      .clk         (clk),
      .reset_n     (reset_n),
      .board_ctrl  (board_ctrl),
      .parity_fail (parity_fail),
      .nmi_enable  (nmi_enable),
      .nmi         (nmi)
   );

endmodule

// File: source/nmi_control.sv
////////////////////////////////////////////////////////////////////////////
// NMI control
// RAM parity and I/O channel check latches, masked into the CPU NMI
////////////////////////////////////////////////////////////////////////////

module nmi_control
   import map_pkg::*;
(
   input  logic        clk,
   input  logic        reset_n,
   input  board_ctrl_t board_ctrl,
   input  logic        parity_fail,
   input  logic        nmi_enable,
   output logic        nmi
);

   logic parity_latch;
   logic io_check_latch;

   // parity check latch
   // the enable doubles as the clear, as on the board
   always_ff @(posedge clk) begin
      if (!reset_n) begin
         parity_latch <= 1'b0;
      end else if (!board_ctrl.ram_check_en) begin
         parity_latch <= 1'b0;
      end else if (parity_fail) begin
         parity_latch <= 1'b1;
      end
   end

   // I/O channel check latch, same arrangement
   always_ff @(posedge clk) begin
      if (!reset_n) begin
         io_check_latch <= 1'b0;
      end else if (!board_ctrl.io_check_en) begin
         io_check_latch <= 1'b0;
      end else if (board_ctrl.io_ch_ck) begin
         io_check_latch <= 1'b1;
      end
   end

   // masked by the NMI register
   assign nmi = nmi_enable && (parity_latch || io_check_latch);

endmodule

// File: source/dma_arbiter.sv
////////////////////////////////////////////////////////////////////////////
// DMA hold arbiter
// hold request/acknowledge chain, staggered address enables, CPU ready
////////////////////////////////////////////////////////////////////////////

module dma_arbiter (
   input  logic clk,
   input  logic reset_n,
   input  logic hold_req,
   input  logic cycle_valid,
   input  logic bus_lock,
   output logic hold_ack,
   output logic aen_brd,
   output logic dma_aen,
   output logic cycle_ready
);

   logic bus_idle;
   logic aen_dly;  // aen_brd one clock later

   // CPU has nothing pending and no locked sequence running
   assign bus_idle = !cycle_valid && !bus_lock;

   // hold acknowledge
   // granted only from an idle bus, kept while the request stays up
   always_ff @(posedge clk) begin
      if (!reset_n) begin
         hold_ack <= 1'b0;
      end else if (!hold_req) begin
         hold_ack <= 1'b0;  // release on the first edge
      end else if (bus_idle) begin
         hold_ack <= 1'b1;
      end
   end

   // board address enable follows hold_ack by a clock
   always_ff @(posedge clk) begin
      if (!reset_n) begin
         aen_brd <= 1'b0;
      end else begin
         aen_brd <= hold_ack;
      end
   end

   // second stage for the DMA controller address enable
   always_ff @(posedge clk) begin
      if (!reset_n) begin
         aen_dly <= 1'b0;
      end else begin
         aen_dly <= aen_brd;
      end
   end

   // rises a clock after aen_brd, drops together with it
   assign dma_aen = aen_dly && aen_brd;

   // CPU waits while DMA owns or is taking the bus
   assign cycle_ready = !(hold_ack || aen_brd);

endmodule

// File: source/mem_decoder.sv
////////////////////////////////////////////////////////////////////////////
// Memory decoder
// ROM socket select, RAM bank select and read parity check
////////////////////////////////////////////////////////////////////////////

module mem_decoder
   import bus_pkg::*;
   import map_pkg::*;
(
   input  logic        clk,
   input  logic        reset_n,
   input  bus_cycle_t  cycle,
   input  logic        accept,
   output mem_select_t mem_sel,
   output logic        parity_fail
);

   logic        is_mem;
   logic        rom_hit;
   logic        ram_hit;
   logic        bad_parity;
   mem_select_t sel_next;

   assign is_mem = (cycle.cmd == mem_read || cycle.cmd == mem_write);

   // ROM answers reads only, top 64k of the address space
   assign rom_hit = (cycle.cmd == mem_read) && (cycle.addr[19:16] == rom_segment);

   // RAM sits in the low 256k
   assign ram_hit = is_mem && (cycle.addr[19:18] == 2'b00);

   // odd parity over data plus parity bit, even count is an error
   assign bad_parity = ~^{cycle.data, cycle.parity};

   always_comb begin
      sel_next = '0;
      if (rom_hit) begin
         sel_next.rom_cs = 8'b1 << cycle.addr[15:13];  // 8k per socket
      end
      if (ram_hit) begin
         sel_next.ram_bank = ram_banks'(1) << cycle.addr[17:16];
      end
   end

   // selects and parity result live for one cycle after acceptance
   always_ff @(posedge clk) begin
      if (!reset_n) begin
         mem_sel     <= '0;
         parity_fail <= 1'b0;
      end else begin
         if (accept) begin
            mem_sel <= sel_next;
         end else begin
            mem_sel <= '0;
         end
         parity_fail <= accept && ram_hit && (cycle.cmd == mem_read) && bad_parity;
      end
   end

endmodule

// File: source/io_decoder.sv
////////////////////////////////////////////////////////////////////////////
// I/O port decoder
// peripheral chip selects, DMA page registers and the NMI mask register
////////////////////////////////////////////////////////////////////////////

module io_decoder
   import bus_pkg::*;
   import map_pkg::*;
(
   input  logic                  clk,
   input  logic                  reset_n,
   input  bus_cycle_t            cycle,
   input  logic                  accept,
   input  logic [1:0]            dma_chan,
   output io_select_t            io_sel,
   output logic [page_width-1:0] dma_page,
   output logic                  nmi_enable
);

   logic [page_width-1:0] page_reg [0:3];  // one per DMA channel
   logic                  port_hit;
   logic                  is_write;
   logic [2:0]            group;
   logic                  page_wr;
   logic                  mask_wr;
   io_select_t            sel_next;

   // only the low 10 address bits decode on the board,
   // bits 9..8 set means an expansion card port
   assign port_hit = (cycle.cmd == io_read || cycle.cmd == io_write) &&
                     (cycle.addr[9:8] == 2'b00);
   assign is_write = (cycle.cmd == io_write);
   assign group    = cycle.addr[7:5];

   assign page_wr = accept && port_hit && is_write && (group == io_group_page);
   assign mask_wr = accept && port_hit && is_write && (group == io_group_nmi);

   // peripheral selects, reads and writes alike
   always_comb begin
      sel_next = '0;
      if (port_hit) begin
         case (group)
            io_group_dma:   sel_next.dma   = 1'b1;
            io_group_intr:  sel_next.intr  = 1'b1;
            io_group_timer: sel_next.timer = 1'b1;
            io_group_ppi:   sel_next.ppi   = 1'b1;
            default:        sel_next       = '0;  // page, nmi, 6 and 7
         endcase
      end
   end

   // select valid only in the cycle after acceptance
   always_ff @(posedge clk) begin
      if (!reset_n) begin
         io_sel <= '0;
      end else if (accept) begin
         io_sel <= sel_next;
      end else begin
         io_sel <= '0;
      end
   end

   // page registers, write only from the CPU side
   always_ff @(posedge clk) begin
      if (!reset_n) begin
         for (int i = 0; i < 4; i++) begin
            page_reg[i] <= '0;
         end
      end else if (page_wr) begin
         page_reg[cycle.addr[1:0]] <= cycle.data[page_width-1:0];
      end
   end

   // upper address bits during DMA come from the active channel
   assign dma_page = page_reg[dma_chan];

   // NMI mask, data bit 7 enables
   always_ff @(posedge clk) begin
      if (!reset_n) begin
         nmi_enable <= 1'b0;
      end else if (mask_wr) begin
         nmi_enable <= cycle.data[7];
      end
   end

endmodule

// File: source/map_pkg.sv
////////////////////////////////////////////////////////////////////////////
// System board address map
// I/O port groups, memory map constants, chip select structs and
// the board control bits normally taken from PPI port B
////////////////////////////////////////////////////////////////////////////

package map_pkg;

   // I/O port groups, the value of port address bits 7..5
   localparam logic [2:0] io_group_dma   = 3'd0;  // 8237 at 00h
   localparam logic [2:0] io_group_intr  = 3'd1;  // 8259 at 20h
   localparam logic [2:0] io_group_timer = 3'd2;  // 8253 at 40h
   localparam logic [2:0] io_group_ppi   = 3'd3;  // 8255 at 60h
   localparam logic [2:0] io_group_page  = 3'd4;  // page regs at 80h
   localparam logic [2:0] io_group_nmi   = 3'd5;  // nmi mask at A0h

   // memory map
   localparam logic [3:0] rom_segment = 4'hF;  // address bits 19..16
   localparam int         ram_banks   = 4;     // 64k banks below 40000h

   // DMA page register width, supplies address bits 19..16
   localparam int page_width = 4;

   // peripheral chip selects, one-hot
   typedef struct packed {
      logic dma;
      logic intr;
      logic timer;
      logic ppi;
   } io_select_t;

   // memory selects
   typedef struct packed {
      logic [7:0]           rom_cs;    // one 8k ROM socket each
      logic [ram_banks-1:0] ram_bank;
   } mem_select_t;

   // board control, active high
   typedef struct packed {
      logic ram_check_en;  // RAM parity check enable
      logic io_check_en;   // I/O channel check enable
      logic io_ch_ck;      // I/O channel check from the expansion slots
   } board_ctrl_t;

endpackage

// File: source/bus_pkg.sv
////////////////////////////////////////////////////////////////////////////
// CPU bus cycle definitions
// command encoding and the packed cycle carried on the valid/ready handshake
////////////////////////////////////////////////////////////////////////////

package bus_pkg;

   // system bus widths
   localparam int addr_width = 20;  // 1 MB address space
   localparam int data_width = 8;

   // bus command, as decoded from the CPU status lines
   typedef enum logic [1:0] {
      mem_read  = 2'd0,
      mem_write = 2'd1,
      io_read   = 2'd2,
      io_write  = 2'd3
   } bus_cmd_t;

   // one bus cycle as presented by the CPU side
   // parity is the memory parity bit returned with RAM read data,
   // it has no meaning on writes or I/O cycles
   typedef struct packed {
      logic [addr_width-1:0] addr;
      bus_cmd_t              cmd;
      logic [data_width-1:0] data;
      logic                  parity;  // odd parity over data on reads
   } bus_cycle_t;

endpackage
